/* Bender.yml */
package:
  name: rob

export_include_dirs:
  - verilog

sources:
  # design, top level rob_top
  - include_dirs:
      - verilog
    files:
      - verilog/rob_pkg.sv
      - verilog/rob_retire_if.sv
      - verilog/rob_queue.sv
      - verilog/arch_regfile.sv
      - verilog/rob_retire.sv
      - verilog/rob_top.sv
  # testbench, top level rob_tb
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/rob_props.sv
      - tb/rob_tb.sv

/* compile.f */
+incdir+verilog
verilog/rob_pkg.sv
verilog/rob_retire_if.sv
verilog/rob_queue.sv
verilog/arch_regfile.sv
verilog/rob_retire.sv
verilog/rob_top.sv
tb/rob_props.sv
tb/rob_tb.sv

/* tb/rob_props.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_props (
    input logic                   clk,
    input logic                   rst_aL,
    input logic                   flush,
    input logic                   dispatch_ready,
    input logic [`ROB_TAG_W-1:0]  dispatch_tag,
    input logic                   commit_valid,
    input logic                   commit_ready,
    input logic [`ROB_TAG_W-1:0]  commit_tag,
    input logic                   commit_is_branch,
    input logic [`ROB_REG_W-1:0]  commit_dest,
    input logic [`ROB_DATA_W-1:0] commit_payload,
    input logic                   redirect_valid
);
    int fail_cnt = 0;   // assertion failures so far

    // stalled commit register keeps its entry
    a_commit_hold: assert property (
        @(posedge clk) disable iff (!rst_aL)
        (commit_valid && !commit_ready) |=>
            (commit_valid && $stable(commit_tag) && $stable(commit_is_branch) &&
             $stable(commit_dest) && $stable(commit_payload))
    ) else begin
        fail_cnt++;
        $error("commit outputs changed while commit_ready was low");
    end

    a_redirect_pulse: assert property (
        @(posedge clk) disable iff (!rst_aL)
        redirect_valid |=> !redirect_valid
    ) else begin
        fail_cnt++;
        $error("redirect_valid lasted more than one cycle");
    end

    // flush blocks dispatch and the buffer restarts empty at tag 0
    a_flush_blocks: assert property (
        @(posedge clk) disable iff (!rst_aL)
        flush |-> !dispatch_ready ##1 (dispatch_ready && dispatch_tag == '0)
    ) else begin
        fail_cnt++;
        $error("dispatch_ready high during flush or buffer not restarted at tag 0");
    end

    // first edge out of reset
    a_reset_quiet: assert property (
        @(posedge clk) $rose(rst_aL) |-> (!commit_valid && !redirect_valid)
    ) else begin
        fail_cnt++;
        $error("commit_valid or redirect_valid high right after reset");
    end

endmodule

/* tb/rob_tb.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_tb;

    logic                                     clk;
    logic                                     rst_aL;
    logic                                     dispatch_valid;
    logic                                     dispatch_ready;
    logic                                     dispatch_is_branch;
    logic [`ROB_REG_W-1:0]                    dispatch_dest;
    logic [`ROB_TAG_W-1:0]                    dispatch_tag;
    logic [`ROB_WB_PORTS-1:0]                 wb_en;
    logic [`ROB_WB_PORTS-1:0][`ROB_TAG_W-1:0] wb_tag;
    rob_pkg::rob_payload_u [`ROB_WB_PORTS-1:0] wb_payload;
    logic                                     commit_valid;
    logic                                     commit_ready;
    logic [`ROB_TAG_W-1:0]                    commit_tag;
    logic                                     commit_is_branch;
    logic [`ROB_REG_W-1:0]                    commit_dest;
    rob_pkg::rob_payload_u                    commit_payload;
    logic                                     redirect_valid;
    logic [`ROB_DATA_W-2:0]                   redirect_target;
    logic [`ROB_REG_W-1:0]                    reg_rd_addr;
    logic [`ROB_DATA_W-1:0]                   reg_rd_data;

    integer seed;
    int     errors;
    int     commits;
    int     redirects;
    int     wait_cycles;

    // live entries of the model in program order
    logic [`ROB_TAG_W-1:0]  m_tag [$];
    logic                   m_br [$];
    logic [`ROB_REG_W-1:0]  m_dest [$];
    logic                   m_done [$];
    logic [`ROB_DATA_W-1:0] m_pay [$];
    logic [`ROB_TAG_W-1:0]  tail;
    logic [`ROB_DATA_W-1:0] shadow [`ROB_REGS];

    // model of the commit register
    logic                   cm_valid;
    logic [`ROB_TAG_W-1:0]  cm_tag;
    logic                   cm_br;
    logic [`ROB_REG_W-1:0]  cm_dest;
    logic [`ROB_DATA_W-1:0] cm_pay;

    logic                   flush_pend;     // redirect cycle expected now
    logic [`ROB_DATA_W-2:0] flush_target;
    logic                   have_alu;
    logic [`ROB_REG_W-1:0]  last_alu_dest;

    // commit outputs seen at the last check
    logic                   hold_pend;
    logic [`ROB_TAG_W-1:0]  prev_tag;
    logic                   prev_br;
    logic [`ROB_REG_W-1:0]  prev_dest;
    logic [`ROB_DATA_W-1:0] prev_pay;

    rob_top dut0 (
        .clk                (clk),
        .rst_aL             (rst_aL),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .dispatch_is_branch (dispatch_is_branch),
        .dispatch_dest      (dispatch_dest),
        .dispatch_tag       (dispatch_tag),
        .wb_en              (wb_en),
        .wb_tag             (wb_tag),
        .wb_payload         (wb_payload),
        .commit_valid       (commit_valid),
        .commit_ready       (commit_ready),
        .commit_tag         (commit_tag),
        .commit_is_branch   (commit_is_branch),
        .commit_dest        (commit_dest),
        .commit_payload     (commit_payload),
        .redirect_valid     (redirect_valid),
        .redirect_target    (redirect_target),
        .reg_rd_addr        (reg_rd_addr),
        .reg_rd_data        (reg_rd_data)
    );

    bind rob_top rob_props props0 (
        .clk              (clk),
        .rst_aL           (rst_aL),
        .flush            (flush),
        .dispatch_ready   (dispatch_ready),
        .dispatch_tag     (dispatch_tag),
        .commit_valid     (commit_valid),
        .commit_ready     (commit_ready),
        .commit_tag       (commit_tag),
        .commit_is_branch (commit_is_branch),
        .commit_dest      (commit_dest),
        .commit_payload   (commit_payload),
        .redirect_valid   (redirect_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic chance_pct(input int pct);
        return rand_below(100) < pct;
    endfunction

    // one branch in eight gets the mispredict flag in bit 31
    function automatic logic [`ROB_DATA_W-1:0] make_payload(input logic is_br);
        logic [`ROB_DATA_W-1:0] w;
        w = $random(seed);
        if (is_br)
            w[`ROB_DATA_W-1] = (rand_below(8) == 0);
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
        errors++;
    endtask

    // compare outputs just before the edge and advance the model across it
    task automatic check_and_advance();
        logic exp_ready;
        logic take;
        logic new_flush;
        exp_ready = (m_tag.size() < `ROB_ENTRIES) && !flush_pend;
        if (dispatch_ready !== exp_ready)
            report_mismatch("dispatch_ready", exp_ready, dispatch_ready);
        if (exp_ready && dispatch_tag !== tail)
            report_mismatch("dispatch_tag", tail, dispatch_tag);
        if (commit_valid !== cm_valid)
            report_mismatch("commit_valid", cm_valid, commit_valid);
        if (cm_valid) begin
            if (commit_tag !== cm_tag)
                report_mismatch("commit_tag", cm_tag, commit_tag);
            if (commit_is_branch !== cm_br)
                report_mismatch("commit_is_branch", cm_br, commit_is_branch);
            if (commit_dest !== cm_dest)
                report_mismatch("commit_dest", cm_dest, commit_dest);
            if (commit_payload !== cm_pay)
                report_mismatch("commit_payload", cm_pay, commit_payload);
        end
        if (hold_pend) begin
            if (commit_tag !== prev_tag || commit_is_branch !== prev_br ||
                commit_dest !== prev_dest || commit_payload !== prev_pay) begin
                $display("commit outputs changed under back-pressure at %0t", $time);
                errors++;
            end
        end
        if (redirect_valid !== flush_pend)
            report_mismatch("redirect_valid", flush_pend, redirect_valid);
        if (flush_pend && redirect_target !== flush_target)
            report_mismatch("redirect_target", flush_target, redirect_target);
        if (reg_rd_data !== shadow[reg_rd_addr])
            report_mismatch("reg_rd_data", shadow[reg_rd_addr], reg_rd_data);

        hold_pend = commit_valid && !commit_ready;
        prev_tag  = commit_tag;
        prev_br   = commit_is_branch;
        prev_dest = commit_dest;
        prev_pay  = commit_payload;

        take      = (m_tag.size() > 0) && m_done[0] && !flush_pend &&
                    (!cm_valid || commit_ready);
        new_flush = 1'b0;
        if (cm_valid && commit_ready)
            commits++;
        if (take) begin
            cm_valid = 1'b1;
            cm_tag   = m_tag[0];
            cm_br    = m_br[0];
            cm_dest  = m_dest[0];
            cm_pay   = m_pay[0];
            if (!m_br[0]) begin
                shadow[m_dest[0]] = m_pay[0];   // visible after this edge
                have_alu          = 1'b1;
                last_alu_dest     = m_dest[0];
            end else if (m_pay[0][`ROB_DATA_W-1]) begin
                new_flush    = 1'b1;
                flush_target = m_pay[0][`ROB_DATA_W-2:0];
            end
            void'(m_tag.pop_front());
            void'(m_br.pop_front());
            void'(m_dest.pop_front());
            void'(m_done.pop_front());
            void'(m_pay.pop_front());
        end else if (commit_ready) begin
            cm_valid = 1'b0;
        end

        if (flush_pend) begin
            // everything younger than the branch is gone
            m_tag.delete();
            m_br.delete();
            m_dest.delete();
            m_done.delete();
            m_pay.delete();
            tail = '0;
            redirects++;
        end else begin
            for (int p = 0; p < `ROB_WB_PORTS; p++) begin
                for (int k = 0; k < m_tag.size(); k++) begin
                    if (wb_en[p] && m_tag[k] == wb_tag[p]) begin
                        m_done[k] = 1'b1;
                        m_pay[k]  = wb_payload[p];
                    end
                end
            end
            if (dispatch_valid && exp_ready) begin
                m_tag.push_back(tail);
                m_br.push_back(dispatch_is_branch);
                m_dest.push_back(dispatch_dest);
                m_done.push_back(1'b0);
                m_pay.push_back('x);
                tail = tail + 1'b1;
            end
        end
        flush_pend = new_flush;
    endtask

    task automatic run_cycle(input logic draining);
        int free_idx [$];
        int n;
        int idx;
        int r;
        @(posedge clk);
        #1;
        dispatch_valid     = draining ? 1'b0 : chance_pct(60);
        dispatch_is_branch = chance_pct(30);
        r                  = rand_below(`ROB_REGS);
        dispatch_dest      = r[`ROB_REG_W-1:0];
        wb_en = '0;
        for (int i = 0; i < m_tag.size(); i++) begin
            if (!m_done[i])
                free_idx.push_back(i);
        end
        // distinct live entries per port
        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            if (free_idx.size() > 0 && chance_pct(50)) begin
                n   = rand_below(free_idx.size());
                idx = free_idx[n];
                free_idx.delete(n);
                wb_en[p]      = 1'b1;
                wb_tag[p]     = m_tag[idx];
                wb_payload[p] = make_payload(m_br[idx]);
            end
        end
        commit_ready = draining ? 1'b1 : chance_pct(70);
        if (have_alu && chance_pct(50)) begin
            reg_rd_addr = last_alu_dest;
        end else begin
            r           = rand_below(`ROB_REGS);
            reg_rd_addr = r[`ROB_REG_W-1:0];
        end
        #2;
        check_and_advance();
    endtask

    initial begin
        seed               = 32'h470460f5;
        errors             = 0;
        commits            = 0;
        redirects          = 0;
        rst_aL             = 1'b0;
        dispatch_valid     = 1'b0;
        dispatch_is_branch = 1'b0;
        dispatch_dest      = '0;
        wb_en              = '0;
        wb_tag             = '0;
        wb_payload         = '0;
        commit_ready       = 1'b0;
        reg_rd_addr        = '0;
        tail               = '0;
        cm_valid           = 1'b0;
        flush_pend         = 1'b0;
        have_alu           = 1'b0;
        hold_pend          = 1'b0;
        for (int r = 0; r < `ROB_REGS; r++)
            shadow[r] = '0;

        repeat (16) @(posedge clk);
        #1 rst_aL = 1'b1;

        for (int c = 0; c < 3000; c++)
            run_cycle(1'b0);

        // let every live entry complete and leave
        wait_cycles = 0;
        while ((m_tag.size() > 0 || cm_valid || flush_pend) && wait_cycles < 2000) begin
            run_cycle(1'b1);
            wait_cycles++;
        end
        if (wait_cycles >= 2000) begin
            $display("timeout: buffer did not drain within 2000 cycles");
            errors++;
        end
        run_cycle(1'b1);

        $display("commits %0d, redirects %0d, errors %0d, assertion failures %0d",
                 commits, redirects, errors, dut0.props0.fail_cnt);
        if (errors == 0 && dut0.props0.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog/arch_regfile.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module arch_regfile (
    input  logic                   clk,
    input  logic                   rst_aL,

    input  logic                   wr_en,
    input  logic [`ROB_REG_W-1:0]  wr_addr,
    input  logic [`ROB_DATA_W-1:0] wr_data,

    input  logic [`ROB_REG_W-1:0]  rd_addr,
    output logic [`ROB_DATA_W-1:0] rd_data
);
    logic [`ROB_DATA_W-1:0] regs_r [`ROB_REGS];

    // r0 is writable like any other register
    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            for (int i = 0; i < `ROB_REGS; i++) begin
                regs_r[i] <= '0;
            end
        end else if (wr_en) begin
            regs_r[wr_addr] <= wr_data;
        end
    end

    // stored state only, a same-cycle write shows up after the edge
    assign rd_data = regs_r[rd_addr];

endmodule

/* verilog/rob_macros.svh */
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// buffer geometry, entry count must stay a power of two
`define ROB_ENTRIES 8
`define ROB_TAG_W 3

// writeback ports into the buffer
`define ROB_WB_PORTS 2

// architectural state
`define ROB_REGS 16
`define ROB_REG_W 4
`define ROB_DATA_W 32

`endif

/* verilog/rob_pkg.sv */
`include "rob_macros.svh"

package rob_pkg;

    // one writeback word, read as an alu result or as a branch outcome
    typedef union packed {
        logic [`ROB_DATA_W-1:0] alu_result;
        logic [`ROB_DATA_W-1:0] br_word;    // msb = mispredict, rest = target
    } rob_payload_u;

    // mispredict flag of the branch reading
    function automatic logic br_mispredict(rob_payload_u p);
        return p.br_word[`ROB_DATA_W-1];
    endfunction

    // redirect target of the branch reading, in word units
    function automatic logic [`ROB_DATA_W-2:0] br_target(rob_payload_u p);
        return p.br_word[`ROB_DATA_W-2:0];
    endfunction

endpackage

/* verilog/rob_queue.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_queue (
    input  logic                                     clk,
    input  logic                                     rst_aL,
    input  logic                                     flush,

    input  logic                                     dispatch_valid,
    output logic                                     dispatch_ready,
    input  logic                                     dispatch_is_branch,
    input  logic [`ROB_REG_W-1:0]                    dispatch_dest,
    output logic [`ROB_TAG_W-1:0]                    dispatch_tag,

    input  logic [`ROB_WB_PORTS-1:0]                 wb_en,
    input  logic [`ROB_WB_PORTS-1:0][`ROB_TAG_W-1:0] wb_tag,
    input  rob_pkg::rob_payload_u [`ROB_WB_PORTS-1:0] wb_payload,

    rob_retire_if.queue                              head
);
    // control state, wrap bit on top of each counter
    logic [`ROB_TAG_W:0]    enq_ctr_r;
    logic [`ROB_TAG_W:0]    deq_ctr_r;
    logic [`ROB_ENTRIES-1:0] done_r;

    // per-entry storage
    logic [`ROB_ENTRIES-1:0] is_branch_r;
    logic [`ROB_REG_W-1:0]  dest_r [`ROB_ENTRIES];
    rob_pkg::rob_payload_u  payload_r [`ROB_ENTRIES];

    logic [`ROB_TAG_W-1:0]  enq_ptr;
    logic [`ROB_TAG_W-1:0]  deq_ptr;
    logic                   empty;
    logic                   full;
    logic                   enq_fire;
    logic                   deq_fire;
    logic [`ROB_WB_PORTS-1:0] wb_fire;

    assign enq_ptr = enq_ctr_r[`ROB_TAG_W-1:0];
    assign deq_ptr = deq_ctr_r[`ROB_TAG_W-1:0];

    assign empty = (enq_ctr_r == deq_ctr_r);
    // same slot, different lap
    assign full  = (enq_ctr_r[`ROB_TAG_W] != deq_ctr_r[`ROB_TAG_W]) &&
                   (enq_ptr == deq_ptr);

    // nothing enters during the flush cycle
    assign dispatch_ready = ~full & ~flush;
    assign dispatch_tag   = enq_ptr;             // tail slot is the new tag
    assign enq_fire       = dispatch_valid & dispatch_ready;
    assign wb_fire        = wb_en & {`ROB_WB_PORTS{~flush}};

    // younger entries must not leak out while the flush is pending
    assign head.head_valid     = ~empty & done_r[deq_ptr] & ~flush;
    assign head.head_tag       = deq_ptr;
    assign head.head_is_branch = is_branch_r[deq_ptr];
    assign head.head_dest      = dest_r[deq_ptr];
    assign head.head_payload   = payload_r[deq_ptr];

    assign deq_fire = head.head_valid & head.head_ready;

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            enq_ctr_r <= '0;
            deq_ctr_r <= '0;
            done_r    <= '0;
        end else if (flush) begin
            enq_ctr_r <= '0;
            deq_ctr_r <= '0;
            done_r    <= '0;
        end else begin
            if (enq_fire) begin
                enq_ctr_r       <= enq_ctr_r + 1'b1;
                done_r[enq_ptr] <= 1'b0;    // fresh entry waits for writeback
            end
            if (deq_fire) begin
                deq_ctr_r <= deq_ctr_r + 1'b1;
            end
            // ports never name the same tag, nor the slot being allocated
            for (int i = 0; i < `ROB_WB_PORTS; i++) begin
                if (wb_fire[i]) begin
                    done_r[wb_tag[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            is_branch_r[enq_ptr] <= dispatch_is_branch;
            dest_r[enq_ptr]      <= dispatch_dest;
        end
        for (int i = 0; i < `ROB_WB_PORTS; i++) begin
            if (wb_fire[i]) begin
                payload_r[wb_tag[i]] <= wb_payload[i];
            end
        end
    end

endmodule

/* verilog/rob_retire.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_retire (
    input  logic                   clk,
    input  logic                   rst_aL,

    rob_retire_if.retire           head,

    output logic                   commit_valid,
    input  logic                   commit_ready,
    output logic [`ROB_TAG_W-1:0]  commit_tag,
    output logic                   commit_is_branch,
    output logic [`ROB_REG_W-1:0]  commit_dest,
    output rob_pkg::rob_payload_u  commit_payload,

    output logic                   flush,
    output logic                   redirect_valid,
    output logic [`ROB_DATA_W-2:0] redirect_target,

    input  logic [`ROB_REG_W-1:0]  reg_rd_addr,
    output logic [`ROB_DATA_W-1:0] reg_rd_data
);
    logic take;          // head moves into the commit register
    logic mispredict;
    logic rf_wr_en;
    logic flush_r;

    // room when empty or when the current entry leaves this cycle
    assign head.head_ready = ~commit_valid | commit_ready;
    assign take            = head.head_valid & head.head_ready;

    assign mispredict = head.head_is_branch & rob_pkg::br_mispredict(head.head_payload);
    assign rf_wr_en   = take & ~head.head_is_branch;

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            commit_valid <= 1'b0;
            flush_r      <= 1'b0;
        end else begin
            if (take) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
            flush_r <= take & mispredict;   // high for one cycle only
        end
    end

    // commit outputs only change on a take, so they hold under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            commit_tag       <= head.head_tag;
            commit_is_branch <= head.head_is_branch;
            commit_dest      <= head.head_dest;
            commit_payload   <= head.head_payload;
        end
        if (take && mispredict) begin
            redirect_target <= rob_pkg::br_target(head.head_payload);
        end
    end

    assign flush          = flush_r;
    assign redirect_valid = flush_r;

    // alu results land in architectural state at the retire edge
    arch_regfile u_regfile (
        .clk     (clk),
        .rst_aL  (rst_aL),
        .wr_en   (rf_wr_en),
        .wr_addr (head.head_dest),
        .wr_data (head.head_payload.alu_result),
        .rd_addr (reg_rd_addr),
        .rd_data (reg_rd_data)
    );

endmodule

/* verilog/rob_retire_if.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

interface rob_retire_if;

    logic                   head_valid;     // head entry present and done
    logic                   head_ready;
    logic [`ROB_TAG_W-1:0]  head_tag;
    logic                   head_is_branch;
    logic [`ROB_REG_W-1:0]  head_dest;
    rob_pkg::rob_payload_u  head_payload;

    modport queue (
        output head_valid,
        input  head_ready,
        output head_tag,
        output head_is_branch,
        output head_dest,
        output head_payload
    );

    modport retire (
        input  head_valid,
        output head_ready,
        input  head_tag,
        input  head_is_branch,
        input  head_dest,
        input  head_payload
    );

endinterface

/* verilog/rob_top.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_top (
    input  logic                                     clk,
    input  logic                                     rst_aL,

    // dispatch
    input  logic                                     dispatch_valid,
    output logic                                     dispatch_ready,
    input  logic                                     dispatch_is_branch,
    input  logic [`ROB_REG_W-1:0]                    dispatch_dest,
    output logic [`ROB_TAG_W-1:0]                    dispatch_tag,

    // writeback, one element per port
    input  logic [`ROB_WB_PORTS-1:0]                 wb_en,
    input  logic [`ROB_WB_PORTS-1:0][`ROB_TAG_W-1:0] wb_tag,
    input  rob_pkg::rob_payload_u [`ROB_WB_PORTS-1:0] wb_payload,

    // commit
    output logic                                     commit_valid,
    input  logic                                     commit_ready,
    output logic [`ROB_TAG_W-1:0]                    commit_tag,
    output logic                                     commit_is_branch,
    output logic [`ROB_REG_W-1:0]                    commit_dest,
    output rob_pkg::rob_payload_u                    commit_payload,

    // redirect
    output logic                                     redirect_valid,
    output logic [`ROB_DATA_W-2:0]                   redirect_target,

    // architectural register read
    input  logic [`ROB_REG_W-1:0]                    reg_rd_addr,
    output logic [`ROB_DATA_W-1:0]                   reg_rd_data
);
    logic flush;    // retire back to queue, stays inside

    rob_retire_if head_if ();

    rob_queue u_queue (
        .clk                (clk),
        .rst_aL             (rst_aL),
        .flush              (flush),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .dispatch_is_branch (dispatch_is_branch),
        .dispatch_dest      (dispatch_dest),
        .dispatch_tag       (dispatch_tag),
        .wb_en              (wb_en),
        .wb_tag             (wb_tag),
        .wb_payload         (wb_payload),
        .head               (head_if.queue)
    );

    rob_retire u_retire (
        .clk              (clk),
        .rst_aL           (rst_aL),
        .head             (head_if.retire),
        .commit_valid     (commit_valid),
        .commit_ready     (commit_ready),
        .commit_tag       (commit_tag),
        .commit_is_branch (commit_is_branch),
        .commit_dest      (commit_dest),
        .commit_payload   (commit_payload),
        .flush            (flush),
        .redirect_valid   (redirect_valid),
        .redirect_target  (redirect_target),
        .reg_rd_addr      (reg_rd_addr),
        .reg_rd_data      (reg_rd_data)
    );

endmodule
